/* hdl/imuldiv_pkg.sv */
/*
 * Shared types for the iterative integer divider.
 * Import into a module body, or use scoped names in port lists.
 */

package imuldiv_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------

  // operand width; default for the top-level XLEN parameter
  parameter int xlen = 32;

  // ----------------------------------------------------------------------
  // data words
  // ----------------------------------------------------------------------

  // one operand, quotient or remainder
  typedef logic [xlen-1:0] div_word_t;

  // response message, remainder in the upper half and quotient below
  typedef logic [2*xlen-1:0] div_resp_t;

  // ----------------------------------------------------------------------
  // encodings
  // ----------------------------------------------------------------------

  // request function code
  typedef enum logic {
    div_unsigned = 1'b0,
    div_signed   = 1'b1
  } div_fn_t;

  // controller states: wait for request, 32 steps, sign fix, hold response
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    fix  = 2'd2,
    done = 2'd3
  } div_state_t;

endpackage

/* hdl/div_operand_decode.sv */
/*
 * Decode stage of the divider: operand magnitudes and result sign flags.
 * Flags and divisor are captured on the accept edge.
 */

`timescale 1ns/1ns

module div_operand_decode #(
  parameter int XLEN = imuldiv_pkg::xlen
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   accept,
  input  imuldiv_pkg::div_fn_t   req_fn,
  input  imuldiv_pkg::div_word_t req_a,
  input  imuldiv_pkg::div_word_t req_b,
  output imuldiv_pkg::div_word_t mag_a,
  output imuldiv_pkg::div_word_t mag_b,
  output logic                   neg_quot,
  output logic                   neg_rem
);

  import imuldiv_pkg::*;

  // sign bits only count for a signed request
  logic    sign_a;
  logic    sign_b;
  div_fn_t fn_q;
  logic    sign_a_q;
  logic    sign_b_q;

  assign sign_a = (req_fn == div_signed) && req_a[XLEN-1];
  assign sign_b = (req_fn == div_signed) && req_b[XLEN-1];

  // dividend magnitude goes straight to the datapath load
  assign mag_a = sign_a ? (~req_a + 1'b1) : req_a;

  // capture function, raw operand signs and divisor magnitude
  always_ff @(posedge clk) begin
    if (reset) begin
      fn_q     <= div_unsigned;
      sign_a_q <= 1'b0;
      sign_b_q <= 1'b0;
    end else if (accept) begin
      fn_q     <= req_fn;
      sign_a_q <= req_a[XLEN-1];
      sign_b_q <= req_b[XLEN-1];
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mag_b <= sign_b ? (~req_b + 1'b1) : req_b;
    end
  end

  // quotient negative on differing signs, remainder follows the dividend
  assign neg_quot = (fn_q == div_signed) && (sign_a_q ^ sign_b_q);
  assign neg_rem  = (fn_q == div_signed) && sign_a_q;

endmodule

/* hdl/div_iter_ctrl.sv */
/*
 * Controller FSM and step counter of the iterative divider.
 * Sequences accept, XLEN steps, sign fix and the response handshake.
 */

`timescale 1ns/1ns

module div_iter_ctrl #(
  parameter int XLEN = imuldiv_pkg::xlen
) (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  input  logic resp_rdy,
  output logic resp_val,
  output logic accept,
  output logic step_en,
  output logic result_en
);

  import imuldiv_pkg::*;

  // counter just wide enough for step indices 0 .. XLEN-1
  localparam int cnt_w = $clog2(XLEN);

  div_state_t       state;
  logic [cnt_w-1:0] count;
  logic             last_step;

  assign last_step = (count == cnt_w'(XLEN - 1));

  // ----------------------------------------------------------------------
  // state register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      count <= '0;
    end else begin
      case (state)
        idle: begin
          // count already zero here, enters calc cleared
          if (accept) begin
            state <= calc;
          end
        end
        calc: begin
          if (last_step) begin
            state <= fix;
            count <= '0;
          end else begin
            count <= count + 1'b1;
          end
        end
        fix: begin
          state <= done;
        end
        done: begin
          // hold the response until the consumer takes it
          if (resp_rdy) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // outputs, decoded from state
  // ----------------------------------------------------------------------

  assign req_rdy   = (state == idle);
  assign accept    = req_rdy && req_val;
  assign step_en   = (state == calc);
  assign result_en = (state == fix);
  assign resp_val  = (state == done);

  // encoding never leaves the four defined states
  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {idle, calc, fix, done});

  // both handshakes are never open at once
  a_one_side: assert property (@(posedge clk) disable iff (reset)
    !(resp_val && req_rdy));

  // counter in range and back at zero whenever the FSM is not stepping
  a_count_range: assert property (@(posedge clk) disable iff (reset)
    count < XLEN && (state == calc || count == '0));

endmodule

/* hdl/div_shift_sub_dpath.sv */
/*
 * Restoring shift-subtract datapath, one quotient bit per step.
 * Loaded on accept; quotient and remainder read out after XLEN steps.
 */

`timescale 1ns/1ns

module div_shift_sub_dpath #(
  parameter int XLEN = imuldiv_pkg::xlen
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   accept,
  input  logic                   step_en,
  input  imuldiv_pkg::div_word_t mag_a,
  input  imuldiv_pkg::div_word_t mag_b,
  output imuldiv_pkg::div_word_t quot,
  output imuldiv_pkg::div_word_t rem
);

  // working register: partial remainder on top, dividend/quotient below
  // the extra top bit carries the sign of the trial difference
  logic [2*XLEN:0] work;
  logic [2*XLEN:0] shifted;
  logic [2*XLEN:0] divisor;
  logic [2*XLEN:0] diff;

  // ----------------------------------------------------------------------
  // one restoring step
  // ----------------------------------------------------------------------

  assign shifted = work << 1;

  // divisor lined up with the partial remainder field
  assign divisor = {1'b0, mag_b, {XLEN{1'b0}}};
  assign diff    = shifted - divisor;

  always_ff @(posedge clk) begin
    if (reset) begin
      work <= '0;
    end else if (accept) begin
      work <= {{(XLEN+1){1'b0}}, mag_a};
    end else if (step_en) begin
      // non-negative difference: keep it and shift in a one
      if (!diff[2*XLEN]) begin
        work <= {diff[2*XLEN:1], 1'b1};
      end else begin
        work <= shifted;
      end
    end
  end

  // ----------------------------------------------------------------------
  // outputs
  // ----------------------------------------------------------------------

  assign quot = work[XLEN-1:0];
  assign rem  = work[2*XLEN-1:XLEN];

  // a new load never lands in the middle of an iteration
  a_no_load_in_calc: assert property (@(posedge clk) disable iff (reset)
    !(step_en && accept));

endmodule

/* hdl/div_result_fix.sv */
/*
 * Result stage: applies the result signs and holds the response.
 * Loads on result_en and keeps the message until the next load.
 */

`timescale 1ns/1ns

module div_result_fix #(
  parameter int XLEN = imuldiv_pkg::xlen
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   result_en,
  input  imuldiv_pkg::div_word_t quot,
  input  imuldiv_pkg::div_word_t rem,
  input  logic                   neg_quot,
  input  logic                   neg_rem,
  output imuldiv_pkg::div_resp_t resp_msg
);

  logic [XLEN-1:0] quot_fix;
  logic [XLEN-1:0] rem_fix;

  // ----------------------------------------------------------------------
  // sign fix
  // ----------------------------------------------------------------------

  // two's-complement negate where the flag says so
  assign quot_fix = neg_quot ? (~quot + 1'b1) : quot;
  assign rem_fix  = neg_rem  ? (~rem + 1'b1)  : rem;

  // ----------------------------------------------------------------------
  // response register
  // ----------------------------------------------------------------------

  // remainder over quotient; stays put while the response waits
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_msg <= '0;
    end else if (result_en) begin
      resp_msg <= {rem_fix, quot_fix};
    end
  end

endmodule

/* hdl/int_div_iterative.sv */
/*
 * Iterative 32-bit integer divider, one request in flight.
 * Request and response both use a val/rdy handshake.
 */

`timescale 1ns/1ns

module int_div_iterative #(
  parameter int XLEN = imuldiv_pkg::xlen
) (
  input  logic                   clk,
  input  logic                   reset,
  input  imuldiv_pkg::div_fn_t   req_fn,
  input  imuldiv_pkg::div_word_t req_a,
  input  imuldiv_pkg::div_word_t req_b,
  input  logic                   req_val,
  output logic                   req_rdy,
  output imuldiv_pkg::div_resp_t resp_msg,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  import imuldiv_pkg::*;

  // controller strobes
  logic accept;
  logic step_en;
  logic result_en;

  // decode to datapath and result stage
  div_word_t mag_a;
  div_word_t mag_b;
  logic      neg_quot;
  logic      neg_rem;

  // datapath to result stage
  div_word_t quot;
  div_word_t rem;

  div_operand_decode #(.XLEN(XLEN)) div_operand_decode_inst (
    .clk      (clk),
    .reset    (reset),
    .accept   (accept),
    .req_fn   (req_fn),
    .req_a    (req_a),
    .req_b    (req_b),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .neg_quot (neg_quot),
    .neg_rem  (neg_rem)
  );

  div_iter_ctrl #(.XLEN(XLEN)) div_iter_ctrl_inst (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_rdy  (resp_rdy),
    .resp_val  (resp_val),
    .accept    (accept),
    .step_en   (step_en),
    .result_en (result_en)
  );

  div_shift_sub_dpath #(.XLEN(XLEN)) div_shift_sub_dpath_inst (
    .clk     (clk),
    .reset   (reset),
    .accept  (accept),
    .step_en (step_en),
    .mag_a   (mag_a),
    .mag_b   (mag_b),
    .quot    (quot),
    .rem     (rem)
  );

  div_result_fix #(.XLEN(XLEN)) div_result_fix_inst (
    .clk       (clk),
    .reset     (reset),
    .result_en (result_en),
    .quot      (quot),
    .rem       (rem),
    .neg_quot  (neg_quot),
    .neg_rem   (neg_rem),
    .resp_msg  (resp_msg)
  );

  // response message frozen while the controller waits in done
  a_msg_stable: assert property (@(posedge clk) disable iff (reset)
    (div_iter_ctrl_inst.state == done && !resp_rdy) |=> $stable(resp_msg));

  // resp_val goes high on the edge after the fix cycle, seen one edge later
  a_latency: assert property (@(posedge clk) disable iff (reset)
    accept |-> ##(XLEN + 2) resp_val);

endmodule

/* dv/int_div_iterative_tb.sv */
/*
 * Testbench for the iterative divider: replays dv/div_trace.txt through the
 * request handshake, adds random response back-pressure, checks each response.
 */

`timescale 1ns/1ns

module int_div_iterative_tb;

  import imuldiv_pkg::*;

  localparam int reset_cycles = 16;
  localparam int max_tests    = 64;

  // DUT ports
  logic      clk;
  logic      reset;
  div_fn_t   req_fn;
  div_word_t req_a;
  div_word_t req_b;
  logic      req_val;
  logic      req_rdy;
  div_resp_t resp_msg;
  logic      resp_val;
  logic      resp_rdy;

  // trace contents, one entry per test
  logic [8*32-1:0] t_name [max_tests];
  div_fn_t         t_fn   [max_tests];
  div_word_t       t_a    [max_tests];
  div_word_t       t_b    [max_tests];
  div_word_t       t_quot [max_tests];
  div_word_t       t_rem  [max_tests];

  int n_tests     = 0;
  int pass_count  = 0;
  int fail_count  = 0;
  int test_errors = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  int_div_iterative #(.XLEN(xlen)) int_div_iterative_inst (
    .clk      (clk),
    .reset    (reset),
    .req_fn   (req_fn),
    .req_a    (req_a),
    .req_b    (req_b),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // ----------------------------------------------------------------------
  // watchdog, limit set once the trace length is known
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the DUT hung, no response after %0d cycles", cycle_count);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  // drive and sample point: 5 ns after the rising edge
  task automatic step_clock();
    @(posedge clk);
    #5;
  endtask

  task automatic note_failure(input logic [8*32-1:0] name, input string what);
    $display("%0s: %0s", name, what);
    test_errors++;
  endtask

  task automatic check_quot(input logic [8*32-1:0] name, input div_word_t expected,
                            input div_word_t actual);
    if (actual !== expected) begin
      $display("ERROR %0s quotient: expected %h, actual %h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_rem(input logic [8*32-1:0] name, input div_word_t expected,
                           input div_word_t actual);
    if (actual !== expected) begin
      $display("ERROR %0s remainder: expected %h, actual %h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_latency(input logic [8*32-1:0] name, input int expected,
                               input int actual);
    if (actual != expected) begin
      $display("ERROR %0s latency: expected %0d, actual %0d", name, expected, actual);
      test_errors++;
    end
  endtask

  // lines starting with # are comments; fields are whitespace separated
  task automatic load_trace();
    int              fd;
    int              fields;
    string           line;
    logic [8*32-1:0] name;
    logic [3:0]      fn_bits;
    div_word_t       a;
    div_word_t       b;
    div_word_t       q;
    div_word_t       r;
    fd = $fopen("dv/div_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file dv/div_trace.txt");
      fail_count++;
      return;
    end
    while (!$feof(fd) && n_tests < max_tests) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%s %h %h %h %h %h", name, fn_bits, a, b, q, r);
        if (fields == 6) begin
          t_name[n_tests] = name;
          t_fn[n_tests]   = div_fn_t'(fn_bits[0]);
          t_a[n_tests]    = a;
          t_b[n_tests]    = b;
          t_quot[n_tests] = q;
          t_rem[n_tests]  = r;
          n_tests++;
        end else begin
          $display("malformed trace line: %0s", line);
          fail_count++;
        end
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------------------
  // one division, request through response
  // ----------------------------------------------------------------------

  task automatic run_test(input int idx);
    int        latency;
    int        hold;
    bit        rdy_seen;
    div_resp_t held_msg;
    test_errors = 0;
    rdy_seen    = 1'b0;
    req_fn   = t_fn[idx];
    req_a    = t_a[idx];
    req_b    = t_b[idx];
    req_val  = 1'b1;
    resp_rdy = 1'b0;
    while (!req_rdy) begin
      step_clock();
    end
    // this edge accepts
    step_clock();
    // decoy operands stay valid, the busy unit must ignore them
    req_a = ~t_a[idx];
    req_b = ~t_b[idx];
    latency = 0;
    while (!resp_val) begin
      if (req_rdy) begin
        rdy_seen = 1'b1;
      end
      step_clock();
      latency++;
    end
    if (rdy_seen) begin
      note_failure(t_name[idx], "req_rdy went high while a division was in progress");
    end
    // fix state adds one edge after the xlen steps
    check_latency(t_name[idx], xlen + 1, latency);
    hold     = int'($urandom % 8);
    held_msg = resp_msg;
    repeat (hold) begin
      step_clock();
      if (!resp_val || req_rdy) begin
        note_failure(t_name[idx], "handshake changed while the response was held back");
      end
      if (resp_msg !== held_msg) begin
        note_failure(t_name[idx], "response message changed while resp_val was high");
      end
    end
    resp_rdy = 1'b1;
    step_clock();
    resp_rdy = 1'b0;
    req_val  = 1'b0;
    if (!req_rdy || resp_val) begin
      note_failure(t_name[idx], "unit did not return to idle after the response transfer");
    end
    check_quot(t_name[idx], t_quot[idx], held_msg[xlen-1:0]);
    check_rem(t_name[idx], t_rem[idx], held_msg[2*xlen-1:xlen]);
    if (test_errors == 0) begin
      pass_count++;
      $display("test %0s: ok, latency %0d, held %0d", t_name[idx], latency, hold);
    end else begin
      fail_count++;
      $display("test %0s: failed with %0d errors", t_name[idx], test_errors);
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    void'($urandom(83));
    reset    = 1'b1;
    req_fn   = div_unsigned;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    load_trace();
    // worst case per test: 34 fixed cycles, 8 held, a few for handshakes
    cycle_limit = n_tests * (34 + 8 + 4) + reset_cycles;
    repeat (reset_cycles) @(posedge clk);
    #5;
    reset = 1'b0;
    if (!req_rdy || resp_val || resp_msg !== '0) begin
      $display("after reset the unit is not idle with a cleared response");
      fail_count++;
    end
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    $display("tests run: %0d, passed: %0d, failed: %0d", n_tests, pass_count, fail_count);
    if (fail_count == 0 && n_tests > 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* dv/div_trace.txt */
# name fn(0 unsigned, 1 signed) a b expected_quotient expected_remainder
# all numbers hex; quotient and remainder as 32-bit two's complement
udiv_basic        0 00000064 00000007 0000000e 00000002
udiv_top_bit      0 ffffffff 00000010 0fffffff 0000000f
udiv_big_divisor  0 80000000 80000001 00000000 80000000
udiv_equal        0 12345678 12345678 00000001 00000000
udiv_top_both     0 fffffffe 80000000 00000001 7ffffffe
udiv_small_big    0 00000003 00000010 00000000 00000003
udiv_by_one       0 deadbeef 00000001 deadbeef 00000000
udiv_mixed        0 87654321 00001000 00087654 00000321
sdiv_pos_pos      1 00000064 00000007 0000000e 00000002
sdiv_neg_pos      1 ffffff9c 00000007 fffffff2 fffffffe
sdiv_pos_neg      1 00000064 fffffff9 fffffff2 00000002
sdiv_neg_neg      1 ffffff9c fffffff9 0000000e fffffffe
sdiv_min_neg1     1 80000000 ffffffff 80000000 00000000
sdiv_min_pos      1 80000000 00000002 c0000000 00000000
sdiv_neg_small    1 fffffffd 00000010 00000000 fffffffd
sdiv_by_neg1      1 00001234 ffffffff ffffedcc 00000000
sdiv_neg_pow2     1 87654321 00001000 fff87655 fffff321
udiv_by_zero      0 0000abcd 00000000 ffffffff 0000abcd
sdiv_zero_pos     1 00000005 00000000 ffffffff 00000005
sdiv_zero_neg     1 fffffffb 00000000 00000001 fffffffb

/* vlog.f */
hdl/imuldiv_pkg.sv
hdl/div_operand_decode.sv
hdl/div_iter_ctrl.sv
hdl/div_shift_sub_dpath.sv
hdl/div_result_fix.sv
hdl/int_div_iterative.sv
dv/int_div_iterative_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the divider testbench with Verilator, run it, judge the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal \
  --top-module int_div_iterative_tb -f vlog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vint_div_iterative_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
  exit 1
fi
exit 0
